// ==== flist.f ====
rtl/host_pkg.sv
rtl/cfg_reg_if.sv
rtl/cfg_lite_slave.sv
rtl/llc_cfg_regs.sv
rtl/perf_event_counters.sv
rtl/dma_evt_sync.sv
rtl/host_domain.sv
tests/tb_host_domain.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the host domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_host_domain \
  -f flist.f -o sim_host > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/sim_host > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0

// ==== tests/tb_host_domain.sv ====
// Testbench for the host domain, checks bus register access, event counters and DMA crossing
`default_nettype none

module tb_host_domain;
  import host_pkg::*;

  localparam int unsigned CNT_WIDTH = 16;
  localparam int          TIMEOUT   = 200;

  logic               clk_i = 1'b0;
  logic               rst_n_i;
  logic               aw_valid_i;
  logic [LITE_AW-1:0] aw_addr_i;
  logic               aw_ready_o;
  logic               w_valid_i;
  logic [LITE_DW-1:0] w_data_i;
  logic               w_ready_o;
  logic               b_valid_o;
  logic [1:0]         b_resp_o;
  logic               b_ready_i;
  logic               ar_valid_i;
  logic [LITE_AW-1:0] ar_addr_i;
  logic               ar_ready_o;
  logic               r_valid_o;
  logic [LITE_DW-1:0] r_data_o;
  logic [1:0]         r_resp_o;
  logic               r_ready_i;
  logic               llc_read_hit_i;
  logic               llc_read_miss_i;
  logic               llc_write_hit_i;
  logic               llc_write_miss_i;
  logic               dma_pe_evt_valid_i;
  logic               dma_pe_evt_ack_o;
  logic [LITE_DW-1:0] llc_cache_addr_start_o;
  logic [LITE_DW-1:0] llc_cache_addr_end_o;
  logic [LITE_DW-1:0] llc_spm_addr_start_o;

  // Reference model state
  logic [LITE_DW-1:0]   model_win [3];
  logic [CNT_WIDTH-1:0] model_cnt [NUM_EVENTS];
  int                   num_checks = 0;
  int                   num_errors = 0;

  host_domain #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) u_host_domain (.*);

  always #4 clk_i = ~clk_i;

  // One cycle of the register rules, a clear beats an event
  function automatic void model_apply(input logic wr, input logic [2:0] idx,
                                      input logic [LITE_DW-1:0] wdata,
                                      input logic [NUM_EVENTS-1:0] evt);
    for (int e = 0; e < NUM_EVENTS; e++) begin
      if (wr && idx == 3'(e + 3)) begin
        model_cnt[e] = '0;
      end else if (evt[e]) begin
        model_cnt[e] = model_cnt[e] + 1'b1;
      end
    end
    if (wr && idx < 3'd3) begin
      model_win[idx] = wdata;
    end
  endfunction

  function automatic logic [LITE_DW-1:0] expected_read(input logic [2:0] idx);
    if (idx < 3'd3) begin
      return model_win[idx];
    end
    // Counts come back zero-extended
    return LITE_DW'(model_cnt[idx - 3'd3]);
  endfunction

  task automatic check_value(input string name, input logic [LITE_DW-1:0] got,
                             input logic [LITE_DW-1:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_counts();
    $display("Checks run: %0d, mismatches: %0d", num_checks, num_errors);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("ERROR: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
    report_counts();
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic axi_write(input logic [2:0] idx, input logic [LITE_DW-1:0] data,
                           input int hold);
    int t;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= {27'd0, idx, 2'b00};
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
    b_ready_i  <= (hold == 0);
    t = 0;
    @(negedge clk_i);
    while (!(aw_ready_o && w_ready_o)) begin
      if (t == TIMEOUT) begin
        abort_on_timeout("write address and data ready");
      end
      t++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    model_apply(1'b1, idx, data, '0);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    t = 0;
    @(negedge clk_i);
    while (!b_valid_o) begin
      if (t == TIMEOUT) begin
        abort_on_timeout("write response");
      end
      t++;
      @(negedge clk_i);
    end
    check_value("b_resp_o", 32'(b_resp_o), '0);
    // Response held back by the master
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_i);
      check_value("b_valid_o", 32'(b_valid_o), 32'd1);
      check_value("aw_ready_o", 32'(aw_ready_o), '0);
      check_value("w_ready_o", 32'(w_ready_o), '0);
    end
    if (hold > 0) begin
      @(posedge clk_i);
      b_ready_i <= 1'b1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("b_valid_o", 32'(b_valid_o), '0);
    check_value("aw_ready_o", 32'(aw_ready_o), 32'd1);
  endtask

  task automatic axi_read(input logic [2:0] idx, input int hold);
    int                 t;
    logic [LITE_DW-1:0] data;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= {27'd0, idx, 2'b00};
    r_ready_i  <= (hold == 0);
    t = 0;
    @(negedge clk_i);
    while (!ar_ready_o) begin
      if (t == TIMEOUT) begin
        abort_on_timeout("read address ready");
      end
      t++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    t = 0;
    @(negedge clk_i);
    while (!r_valid_o) begin
      if (t == TIMEOUT) begin
        abort_on_timeout("read response");
      end
      t++;
      @(negedge clk_i);
    end
    data = r_data_o;
    check_value("r_data_o", data, expected_read(idx));
    check_value("r_resp_o", 32'(r_resp_o), '0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_i);
      check_value("r_valid_o", 32'(r_valid_o), 32'd1);
      check_value("r_data_o", r_data_o, data);
      check_value("ar_ready_o", 32'(ar_ready_o), '0);
    end
    if (hold > 0) begin
      @(posedge clk_i);
      r_ready_i <= 1'b1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("r_valid_o", 32'(r_valid_o), '0);
    check_value("ar_ready_o", 32'(ar_ready_o), 32'd1);
  endtask

  task automatic drive_events(input int cycles);
    logic [3:0] evt;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      evt = 4'($urandom);
      llc_read_hit_i   <= evt[0];
      llc_read_miss_i  <= evt[1];
      llc_write_hit_i  <= evt[2];
      llc_write_miss_i <= evt[3];
      model_apply(1'b0, 3'd0, '0, {1'b0, evt});
    end
    @(posedge clk_i);
    llc_read_hit_i   <= 1'b0;
    llc_read_miss_i  <= 1'b0;
    llc_write_hit_i  <= 1'b0;
    llc_write_miss_i <= 1'b0;
  endtask

  // Level change on the cluster side, ack follows after two clk_i cycles
  task automatic toggle_dma(input logic level, input int hold);
    int t;
    @(posedge clk_i);
    if (level && !dma_pe_evt_valid_i) begin
      model_apply(1'b0, 3'd0, '0, 5'b10000);
    end
    dma_pe_evt_valid_i <= level;
    t = 0;
    @(negedge clk_i);
    while (dma_pe_evt_ack_o !== level) begin
      if (t == TIMEOUT) begin
        abort_on_timeout("DMA event acknowledge");
      end
      t++;
      @(negedge clk_i);
    end
    check_value("dma ack latency", 32'(t), 32'd2);
    repeat (hold) @(posedge clk_i);
  endtask

  // Window outputs must follow the model every cycle
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_value("llc_cache_addr_start_o", llc_cache_addr_start_o, model_win[0]);
      check_value("llc_cache_addr_end_o", llc_cache_addr_end_o, model_win[1]);
      check_value("llc_spm_addr_start_o", llc_spm_addr_start_o, model_win[2]);
    end
  end

  initial begin
    void'($urandom(53));
    for (int i = 0; i < 3; i++) begin
      model_win[i] = '0;
    end
    for (int e = 0; e < NUM_EVENTS; e++) begin
      model_cnt[e] = '0;
    end
    rst_n_i            <= 1'b0;
    aw_valid_i         <= 1'b0;
    aw_addr_i          <= '0;
    w_valid_i          <= 1'b0;
    w_data_i           <= '0;
    b_ready_i          <= 1'b1;
    ar_valid_i         <= 1'b0;
    ar_addr_i          <= '0;
    r_ready_i          <= 1'b1;
    llc_read_hit_i     <= 1'b0;
    llc_read_miss_i    <= 1'b0;
    llc_write_hit_i    <= 1'b0;
    llc_write_miss_i   <= 1'b0;
    dma_pe_evt_valid_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(negedge clk_i);
    check_value("b_valid_o", 32'(b_valid_o), '0);
    check_value("r_valid_o", 32'(r_valid_o), '0);
    check_value("dma_pe_evt_ack_o", 32'(dma_pe_evt_ack_o), '0);
    check_value("aw_ready_o", 32'(aw_ready_o), 32'd1);
    check_value("w_ready_o", 32'(w_ready_o), 32'd1);
    check_value("ar_ready_o", 32'(ar_ready_o), 32'd1);
    for (int i = 0; i < 8; i++) begin
      axi_read(3'(i), 0);
    end

    for (int i = 0; i < 3; i++) begin
      axi_write(3'(i), $urandom, 0);
      axi_read(3'(i), 0);
    end

    drive_events(200);
    for (int i = 3; i < 7; i++) begin
      axi_read(3'(i), 0);
    end

    // Writes clear the counters, then counting restarts from zero
    for (int i = 3; i < 7; i++) begin
      axi_write(3'(i), $urandom, 0);
      axi_read(3'(i), 0);
    end
    drive_events(40);
    for (int i = 3; i < 7; i++) begin
      axi_read(3'(i), 0);
    end

    for (int k = 0; k < 6; k++) begin
      toggle_dma((k % 2) == 0, 8 + int'($urandom % 8));
    end
    axi_read(DMA_EVT_CNT, 0);
    axi_write(DMA_EVT_CNT, $urandom, 0);
    axi_read(DMA_EVT_CNT, 0);

    axi_read(CACHE_START, 2 + int'($urandom % 8));
    axi_write(SPM_START, $urandom, 2 + int'($urandom % 8));
    axi_read(SPM_START, 0);

    repeat (4) @(posedge clk_i);
    report_counts();
    if (num_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/host_domain.sv ====
// Host domain top with cache config slave, event counters and DMA event crossing
`default_nettype none

module host_domain
  import host_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 32
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // AXI-Lite write
  input  wire logic               aw_valid_i,
  input  wire logic [LITE_AW-1:0] aw_addr_i,
  output logic                    aw_ready_o,
  input  wire logic               w_valid_i,
  input  wire logic [LITE_DW-1:0] w_data_i,
  output logic                    w_ready_o,
  output logic                    b_valid_o,
  output logic [1:0]              b_resp_o,
  input  wire logic               b_ready_i,
  // AXI-Lite read
  input  wire logic               ar_valid_i,
  input  wire logic [LITE_AW-1:0] ar_addr_i,
  output logic                    ar_ready_o,
  output logic                    r_valid_o,
  output logic [LITE_DW-1:0]      r_data_o,
  output logic [1:0]              r_resp_o,
  input  wire logic               r_ready_i,
  // Cache events
  input  wire logic               llc_read_hit_i,
  input  wire logic               llc_read_miss_i,
  input  wire logic               llc_write_hit_i,
  input  wire logic               llc_write_miss_i,
  // Cluster DMA event
  input  wire logic               dma_pe_evt_valid_i,
  output logic                    dma_pe_evt_ack_o,
  // Cache windows
  output logic [LITE_DW-1:0]      llc_cache_addr_start_o,
  output logic [LITE_DW-1:0]      llc_cache_addr_end_o,
  output logic [LITE_DW-1:0]      llc_spm_addr_start_o
);

  logic [NUM_EVENTS-1:0]           evt_vec;
  logic [NUM_EVENTS-1:0]           cnt_clr;
  logic [NUM_EVENTS*CNT_WIDTH-1:0] cnt_vec;
  logic                            dma_evt_pulse;

  cfg_reg_if u_cfg_reg_if ();

  assign evt_vec[RD_HIT]  = llc_read_hit_i;
  assign evt_vec[RD_MISS] = llc_read_miss_i;
  assign evt_vec[WR_HIT]  = llc_write_hit_i;
  assign evt_vec[WR_MISS] = llc_write_miss_i;
  assign evt_vec[DMA_EVT] = dma_evt_pulse;

  cfg_lite_slave u_cfg_lite_slave (
    .clk_i      ( clk_i        ),
    .rst_n_i    ( rst_n_i      ),
    .aw_valid_i ( aw_valid_i   ),
    .aw_addr_i  ( aw_addr_i    ),
    .aw_ready_o ( aw_ready_o   ),
    .w_valid_i  ( w_valid_i    ),
    .w_data_i   ( w_data_i     ),
    .w_ready_o  ( w_ready_o    ),
    .b_valid_o  ( b_valid_o    ),
    .b_resp_o   ( b_resp_o     ),
    .b_ready_i  ( b_ready_i    ),
    .ar_valid_i ( ar_valid_i   ),
    .ar_addr_i  ( ar_addr_i    ),
    .ar_ready_o ( ar_ready_o   ),
    .r_valid_o  ( r_valid_o    ),
    .r_data_o   ( r_data_o     ),
    .r_resp_o   ( r_resp_o     ),
    .r_ready_i  ( r_ready_i    ),
    .reg_o      ( u_cfg_reg_if )
  );

  llc_cfg_regs #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) u_llc_cfg_regs (
    .clk_i                  ( clk_i                  ),
    .rst_n_i                ( rst_n_i                ),
    .reg_i                  ( u_cfg_reg_if           ),
    .cnt_i                  ( cnt_vec                ),
    .cnt_clr_o              ( cnt_clr                ),
    .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
    .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
    .llc_spm_addr_start_o   ( llc_spm_addr_start_o   )
  );

  perf_event_counters #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) u_perf_event_counters (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .evt_i   ( evt_vec ),
    .clr_i   ( cnt_clr ),
    .cnt_o   ( cnt_vec )
  );

  dma_evt_sync u_dma_evt_sync (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .pulse_o ( dma_evt_pulse      )
  );

endmodule

`default_nettype wire

// ==== rtl/dma_evt_sync.sv ====
// Cluster DMA event receiver, two-flop synchronizer with rising edge pulse
`default_nettype none

module dma_evt_sync (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic valid_i,
  output logic      ack_o,
  output logic      pulse_o
);

  logic [1:0] sync_q;
  logic       prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      prev_q <= sync_q[1];
    end
  end

  // Ack returns the level once it is safe in this domain
  assign ack_o   = sync_q[1];
  assign pulse_o = sync_q[1] & ~prev_q;

  a_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pulse_o |=> !pulse_o)
    else $error("DMA event pulse longer than one cycle");

endmodule

`default_nettype wire

// ==== rtl/perf_event_counters.sv ====
// Wrap-around event counters with per-counter clear
`default_nettype none

module perf_event_counters
  import host_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 32
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic [NUM_EVENTS-1:0]    evt_i,
  input  wire logic [NUM_EVENTS-1:0]    clr_i,
  output logic [NUM_EVENTS*CNT_WIDTH-1:0] cnt_o
);

  logic [NUM_EVENTS-1:0][CNT_WIDTH-1:0] cnt_q;

  for (genvar e = 0; e < NUM_EVENTS; e++) begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[e] <= '0;
      end else if (clr_i[e]) begin
        // Clear beats a coincident event
        cnt_q[e] <= '0;
      end else if (evt_i[e]) begin
        cnt_q[e] <= cnt_q[e] + 1'b1;
      end
    end
  end

  assign cnt_o = cnt_q;

  a_clr_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(clr_i))
    else $error("more than one counter cleared at once");

endmodule

`default_nettype wire

// ==== rtl/llc_cfg_regs.sv ====
// Cache window registers with register decode and read mux over windows and counters
`default_nettype none

module llc_cfg_regs
  import host_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 32
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  cfg_reg_if.regs_mp                           reg_i,
  input  wire logic [NUM_EVENTS*CNT_WIDTH-1:0] cnt_i,
  output logic [NUM_EVENTS-1:0]                cnt_clr_o,
  output logic [LITE_DW-1:0]                   llc_cache_addr_start_o,
  output logic [LITE_DW-1:0]                   llc_cache_addr_end_o,
  output logic [LITE_DW-1:0]                   llc_spm_addr_start_o
);

  localparam int unsigned CNT_BASE = int'(RD_HIT_CNT);

  logic [LITE_DW-1:0] cache_start_q;
  logic [LITE_DW-1:0] cache_end_q;
  logic [LITE_DW-1:0] spm_start_q;
  int unsigned        cnt_sel;

  assign cnt_sel = int'(reg_i.idx) - CNT_BASE;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
    end else if (reg_i.wr_en) begin
      case (reg_i.idx)
        CACHE_START: cache_start_q <= reg_i.wdata;
        CACHE_END:   cache_end_q   <= reg_i.wdata;
        SPM_START:   spm_start_q   <= reg_i.wdata;
        default: ;
      endcase
    end
  end

  // Writes to counter registers become a one-hot clear
  always_comb begin
    cnt_clr_o = '0;
    if (reg_i.wr_en && int'(reg_i.idx) >= CNT_BASE) begin
      cnt_clr_o[cnt_sel] = 1'b1;
    end
  end

  always_comb begin
    reg_i.rdata = '0;
    case (reg_i.idx)
      CACHE_START: reg_i.rdata = cache_start_q;
      CACHE_END:   reg_i.rdata = cache_end_q;
      SPM_START:   reg_i.rdata = spm_start_q;
      // counts are zero-extended
      default:     reg_i.rdata[CNT_WIDTH-1:0] = cnt_i[cnt_sel*CNT_WIDTH +: CNT_WIDTH];
    endcase
  end

  assign llc_cache_addr_start_o = cache_start_q;
  assign llc_cache_addr_end_o   = cache_end_q;
  assign llc_spm_addr_start_o   = spm_start_q;

  a_one_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(reg_i.wr_en && reg_i.rd_en))
    else $error("read and write on the register port in one cycle");

endmodule

`default_nettype wire

// ==== rtl/cfg_lite_slave.sv ====
// AXI-Lite configuration slave, one outstanding read and one outstanding write
`default_nettype none

module cfg_lite_slave
  import host_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // Write channels
  input  wire logic               aw_valid_i,
  input  wire logic [LITE_AW-1:0] aw_addr_i,
  output logic                    aw_ready_o,
  input  wire logic               w_valid_i,
  input  wire logic [LITE_DW-1:0] w_data_i,
  output logic                    w_ready_o,
  output logic                    b_valid_o,
  output logic [1:0]              b_resp_o,
  input  wire logic               b_ready_i,
  // Read channels
  input  wire logic               ar_valid_i,
  input  wire logic [LITE_AW-1:0] ar_addr_i,
  output logic                    ar_ready_o,
  output logic                    r_valid_o,
  output logic [LITE_DW-1:0]      r_data_o,
  output logic [1:0]              r_resp_o,
  input  wire logic               r_ready_i,
  // Register file side
  cfg_reg_if.slave_mp             reg_o
);

  logic               wr_acc;
  logic               rd_acc;
  logic               b_pending_q;
  logic               r_pending_q;
  logic [LITE_DW-1:0] r_data_q;

  assign aw_ready_o = ~b_pending_q;
  assign w_ready_o  = ~b_pending_q;
  assign wr_acc     = aw_valid_i & w_valid_i & ~b_pending_q;

  // Register port is shared, a write in the same cycle holds the read off
  assign ar_ready_o = ~r_pending_q & ~wr_acc;
  assign rd_acc     = ar_valid_i & ar_ready_o;

  assign reg_o.wr_en = wr_acc;
  assign reg_o.rd_en = rd_acc;
  assign reg_o.wdata = w_data_i;
  assign reg_o.idx   = wr_acc ? cfg_reg_e'(aw_addr_i[REG_IDX_W+1:2])
                              : cfg_reg_e'(ar_addr_i[REG_IDX_W+1:2]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_pending_q <= 1'b0;
      r_pending_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        b_pending_q <= 1'b1;
      end else if (b_ready_i) begin
        b_pending_q <= 1'b0;
      end
      if (rd_acc) begin
        r_pending_q <= 1'b1;
      end else if (r_ready_i) begin
        r_pending_q <= 1'b0;
      end
    end
  end

  // Read data captured at acceptance
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= reg_o.rdata;
    end
  end

  assign b_valid_o = b_pending_q;
  assign b_resp_o  = 2'b00;
  assign r_valid_o = r_pending_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = 2'b00;

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else $error("read response changed under back-pressure");

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o)
    else $error("write response dropped under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/cfg_reg_if.sv ====
// Register access port between the configuration bus slave and the register file
`default_nettype none

interface cfg_reg_if
  import host_pkg::*;
();

  logic               wr_en;
  logic               rd_en;
  cfg_reg_e           idx;
  logic [LITE_DW-1:0] wdata;
  // Combinational from idx
  logic [LITE_DW-1:0] rdata;

  modport slave_mp (
    output wr_en,
    output rd_en,
    output idx,
    output wdata,
    input  rdata
  );

  modport regs_mp (
    input  wr_en,
    input  rd_en,
    input  idx,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== rtl/host_pkg.sv ====
// Host domain package with bus widths, register map and event positions
`default_nettype none

package host_pkg;

  // AXI-Lite configuration bus
  localparam int unsigned LITE_AW = 32;
  localparam int unsigned LITE_DW = 32;

  // Register index comes from byte address bits 4:2
  localparam int unsigned REG_IDX_W = 3;

  typedef enum logic [REG_IDX_W-1:0] {
    CACHE_START = 3'd0,
    CACHE_END   = 3'd1,
    SPM_START   = 3'd2,
    RD_HIT_CNT  = 3'd3,
    RD_MISS_CNT = 3'd4,
    WR_HIT_CNT  = 3'd5,
    WR_MISS_CNT = 3'd6,
    DMA_EVT_CNT = 3'd7
  } cfg_reg_e;

  localparam int unsigned NUM_EVENTS = 5;

  // Same order as counter registers 3 to 7
  typedef enum int unsigned {
    RD_HIT  = 0,
    RD_MISS = 1,
    WR_HIT  = 2,
    WR_MISS = 3,
    DMA_EVT = 4
  } evt_e;

endpackage

`default_nettype wire
